// File: hdl/conv_acc_pkg.sv
package conv_acc_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int LANES  = 4;
  localparam int LANE_W = DATA_W / LANES;

  typedef logic signed [LANE_W-1:0] weight_t;

  // strobes coming from the AXI slave side
  typedef struct packed {
    logic              cs;
    logic              oe;
    logic              ar_hs;
    logic              aw_hs;
    logic              w_hs;
    logic              rd_fin;
    logic              wr_fin;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  // one request toward the parameter SRAM, addr is a word index
  typedef struct packed {
    logic              cs;
    logic              oe;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } sram_port_t;

  // a parameter word as stored, or as four weights
  // lane 0 sits in the low byte
  typedef union packed {
    logic [DATA_W-1:0]   raw;
    weight_t [LANES-1:0] lane;
  } param_word_u;

endpackage

// File: hdl/param_sram.sv
`timescale 1ns/100ps

module param_sram
  import conv_acc_pkg::*;
#(
  parameter int PARAM_DEPTH = 8
) (
  input  logic              clk,
  input  sram_port_t        req_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int IDX_W = (PARAM_DEPTH > 1) ? $clog2(PARAM_DEPTH) : 1;

  param_word_u      mem [PARAM_DEPTH];
  logic [IDX_W-1:0] idx;

  assign idx = req_i.addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (req_i.cs && req_i.we) begin
      mem[idx].raw <= req_i.wdata;
    end
  end

  // one cycle read latency, output holds between reads
  always_ff @(posedge clk) begin
    if (req_i.cs && req_i.oe) begin
      rdata_o <= mem[idx].raw;
    end
  end

  // upper address bits are dropped above, so callers must stay in range
  a_addr_in_range: assert property (
    @(posedge clk) req_i.cs |-> (req_i.addr < PARAM_DEPTH)
  );

endmodule

// File: hdl/param_wrapper.sv
`timescale 1ns/100ps

module param_wrapper
  import conv_acc_pkg::*;
#(
  parameter int PARAM_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst,
  // host side
  input  host_req_t         host_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  // engine side
  input  logic              start_i,
  input  logic              finish_i,
  input  sram_port_t        epu_req_i,
  output logic [DATA_W-1:0] epu_rdata_o,
  // parameter SRAM
  output sram_port_t        mem_req_o,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  localparam int IDX_W = (PARAM_DEPTH > 1) ? $clog2(PARAM_DEPTH) : 1;

  typedef enum logic [1:0] {
    IDLE   = 2'h0,
    EPU_RW = 2'h1,
    HOST_R = 2'h2,
    HOST_W = 2'h3
  } wrap_state_t;

  wrap_state_t       state;
  wrap_state_t       state_nxt;
  logic [ADDR_W-1:0] host_word;

  // byte address to word index using only the bits the depth needs
  assign host_word = ADDR_W'(host_i.addr[IDX_W+1:2]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // fixed priority of start over host read over host write
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start_i) begin
          state_nxt = EPU_RW;
        end else if (host_i.ar_hs) begin
          state_nxt = HOST_R;
        end else if (host_i.aw_hs) begin
          state_nxt = HOST_W;
        end
      end
      HOST_R: begin
        if (host_i.rd_fin) begin
          state_nxt = IDLE;
        end
      end
      HOST_W: begin
        if (host_i.wr_fin) begin
          state_nxt = IDLE;
        end
      end
      EPU_RW: begin
        if (finish_i && start_i) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_comb begin
    mem_req_o   = '0;
    epu_rdata_o = '0;
    rdata_o     = '0;
    rvalid_o    = 1'b0;
    case (state)
      EPU_RW: begin
        mem_req_o   = epu_req_i;
        epu_rdata_o = mem_rdata_i;
      end
      HOST_R: begin
        rvalid_o       = 1'b1;
        rdata_o        = mem_rdata_i;
        mem_req_o.cs   = host_i.cs;
        mem_req_o.oe   = host_i.oe;
        mem_req_o.addr = host_word;
      end
      HOST_W: begin
        mem_req_o.cs    = host_i.cs;
        mem_req_o.we    = host_i.w_hs;
        mem_req_o.addr  = host_word;
        mem_req_o.wdata = host_i.wdata;
      end
      default: begin
        // issue the read early so HOST_R starts with valid data
        if (host_i.ar_hs && !start_i) begin
          mem_req_o.cs   = 1'b1;
          mem_req_o.oe   = 1'b1;
          mem_req_o.addr = host_word;
        end
      end
    endcase
  end

  // only a host write may raise the SRAM write enable
  a_no_write_in_read: assert property (
    @(posedge clk) disable iff (rst) mem_req_o.we |-> (state == HOST_W)
  );

  // engine read data comes back while the engine still owns the port
  a_epu_data_gated: assert property (
    @(posedge clk) disable iff (rst) epu_req_i.cs |=> (state == EPU_RW)
  );

endmodule

// File: hdl/conv_dot_engine.sv
`timescale 1ns/100ps

module conv_dot_engine
  import conv_acc_pkg::*;
#(
  parameter int PARAM_DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  param_word_u              act_i,
  output sram_port_t               req_o,
  input  param_word_u              rdata_i,
  output logic                     finish_o,
  output logic signed [DATA_W-1:0] result_o
);

  localparam int IDX_W = (PARAM_DEPTH > 1) ? $clog2(PARAM_DEPTH) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PARAM_DEPTH - 1);

  logic                       start_q;
  logic                       start_rise;
  logic                       issuing;
  logic [IDX_W-1:0]           rd_idx;
  logic                       data_vld;
  logic                       data_last;
  logic signed [2*LANE_W-1:0] lane_prod [LANES];
  logic signed [DATA_W-1:0]   word_sum;
  logic signed [DATA_W-1:0]   acc;

  assign start_rise = start_i && !start_q;

  // read issue, one word per cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q <= 1'b0;
      issuing <= 1'b0;
      rd_idx  <= '0;
    end else begin
      start_q <= start_i;
      if (start_rise) begin
        issuing <= 1'b1;
        rd_idx  <= '0;
      end else if (issuing) begin
        rd_idx <= rd_idx + 1'b1;
        if (rd_idx == LAST_IDX) begin
          issuing <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    req_o      = '0;
    req_o.cs   = issuing;
    req_o.oe   = issuing;
    req_o.addr = ADDR_W'(rd_idx);
  end

  // SRAM answers one cycle after the request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_vld  <= 1'b0;
      data_last <= 1'b0;
    end else begin
      data_vld  <= issuing;
      data_last <= issuing && (rd_idx == LAST_IDX);
    end
  end

  // weight times activation, lane by lane
  always_comb begin
    word_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_prod[i] = rdata_i.lane[i] * act_i.lane[i];
      word_sum     = word_sum + lane_prod[i];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc      <= '0;
      finish_o <= 1'b0;
    end else begin
      if (start_rise) begin
        acc <= '0;
      end else if (data_vld) begin
        acc <= acc + word_sum;
      end
      if (!start_i) begin
        finish_o <= 1'b0;
      end else if (data_vld && data_last) begin
        finish_o <= 1'b1;
      end
    end
  end

  assign result_o = acc;

  // nothing may still be in flight once finish is up
  a_finish_after_reads: assert property (
    @(posedge clk) disable iff (rst) finish_o |-> (!issuing && !data_vld)
  );

endmodule

// File: hdl/conv_param_top.sv
`timescale 1ns/100ps

module conv_param_top
  import conv_acc_pkg::*;
#(
  parameter int PARAM_DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  // host strobes and read return
  input  host_req_t                host_i,
  output logic                     rvalid_o,
  output logic [DATA_W-1:0]        rdata_o,
  // accelerator control
  input  logic                     epu_start_i,
  input  param_word_u              act_i,
  output logic                     epu_finish_o,
  output logic signed [DATA_W-1:0] result_o
);

  sram_port_t        mem_req;
  logic [DATA_W-1:0] mem_rdata;
  sram_port_t        epu_req;
  param_word_u       epu_rdata;

  param_wrapper #(
    .PARAM_DEPTH(PARAM_DEPTH)
  ) wrapper_i (
    .clk        (clk),
    .rst        (rst),
    .host_i     (host_i),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .start_i    (epu_start_i),
    .finish_i   (epu_finish_o),
    .epu_req_i  (epu_req),
    .epu_rdata_o(epu_rdata.raw),
    .mem_req_o  (mem_req),
    .mem_rdata_i(mem_rdata)
  );

  param_sram #(
    .PARAM_DEPTH(PARAM_DEPTH)
  ) sram_i (
    .clk    (clk),
    .req_i  (mem_req),
    .rdata_o(mem_rdata)
  );

  conv_dot_engine #(
    .PARAM_DEPTH(PARAM_DEPTH)
  ) engine_i (
    .clk     (clk),
    .rst     (rst),
    .start_i (epu_start_i),
    .act_i   (act_i),
    .req_o   (epu_req),
    .rdata_i (epu_rdata),
    .finish_o(epu_finish_o),
    .result_o(result_o)
  );

endmodule

// File: tests/tb_conv_param.sv
`timescale 1ns/100ps

module tb_conv_param
  import conv_acc_pkg::*;
();

  localparam int DEPTH      = 8;
  localparam int WAIT_LIMIT = 200;

  typedef enum {OP_WR, OP_RD, OP_RUN} op_e;

  typedef struct {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } row_t;

  logic                     clk;
  logic                     rst;
  host_req_t                host;
  logic                     rvalid_o;
  logic [DATA_W-1:0]        rdata_o;
  logic                     epu_start;
  param_word_u              act;
  logic                     epu_finish_o;
  logic signed [DATA_W-1:0] result_o;

  logic [31:0] seed;
  logic [31:0] shadow [DEPTH];
  row_t        rows [$];

  conv_param_top #(
    .PARAM_DEPTH(DEPTH)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .host_i      (host),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .epu_start_i (epu_start),
    .act_i       (act),
    .epu_finish_o(epu_finish_o),
    .result_o    (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // only the word-index bits of a byte address select a word
  function automatic int word_of(logic [31:0] addr);
    return int'((addr >> 2) % DEPTH);
  endfunction

  // sum of signed weight times signed activation over all words and lanes
  function automatic logic [31:0] dot_ref(logic [31:0] act_v);
    logic signed [31:0] sum;
    logic signed [7:0]  w;
    logic signed [7:0]  a;
    sum = 0;
    for (int i = 0; i < DEPTH; i++) begin
      for (int l = 0; l < 4; l++) begin
        w   = shadow[i][8*l +: 8];
        a   = act_v[8*l +: 8];
        sum = sum + w * a;
      end
    end
    return sum;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp_v);
    if (got !== exp_v) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp_v);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(string what);
    $display("timed out waiting for %s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic add_row(op_e op, logic [31:0] addr, logic [31:0] data);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    if (op == OP_WR) begin
      shadow[word_of(addr)] = data;
      r.exp_val = 32'h0;
    end else if (op == OP_RD) begin
      r.exp_val = shadow[word_of(addr)];
    end else begin
      r.exp_val = dot_ref(data);
    end
    rows.push_back(r);
  endtask

  task automatic host_write(logic [31:0] addr, logic [31:0] data);
    host.cs    = 1'b1;
    host.aw_hs = 1'b1;
    host.addr  = addr;
    @(negedge clk);
    host.aw_hs  = 1'b0;
    host.w_hs   = 1'b1;
    host.wr_fin = 1'b1;
    host.wdata  = data;
    @(negedge clk);
    host = '0;
  endtask

  task automatic host_read(logic [31:0] addr, logic [31:0] exp_v);
    host.cs    = 1'b1;
    host.oe    = 1'b1;
    host.ar_hs = 1'b1;
    host.addr  = addr;
    @(negedge clk);
    host.ar_hs = 1'b0;
    // data is due in the first HOST_R cycle
    check_value("rvalid_o", rvalid_o, 32'h1);
    check_value("rdata_o", rdata_o, exp_v);
    @(negedge clk);
    check_value("rvalid_o", rvalid_o, 32'h1);
    check_value("rdata_o", rdata_o, exp_v);
    host.rd_fin = 1'b1;
    @(negedge clk);
    host = '0;
    check_value("rvalid_o", rvalid_o, 32'h0);
  endtask

  task automatic run_engine(logic [31:0] act_v, logic [31:0] exp_v);
    int cnt;
    act.raw   = act_v;
    epu_start = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!epu_finish_o && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!epu_finish_o) report_timeout("engine finish to rise");
    check_value("result_o", result_o, exp_v);
    // with finish and start high the wrapper alternates EPU_RW and IDLE
    // start is released on the third cycle when the wrapper sits in IDLE
    repeat (3) begin
      @(negedge clk);
      check_value("epu_finish_o", epu_finish_o, 32'h1);
      check_value("result_o", result_o, exp_v);
    end
    epu_start = 1'b0;
    cnt = 0;
    while (epu_finish_o && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (epu_finish_o) report_timeout("engine finish to clear");
    check_value("result_o", result_o, exp_v);
  endtask

  initial begin
    rst       = 1'b1;
    host      = '0;
    epu_start = 1'b0;
    act.raw   = '0;
    seed      = 32'ha660d2ed;

    for (int i = 0; i < DEPTH; i++) begin
      add_row(OP_WR, i * 4, lcg_next());
    end
    for (int i = 0; i < DEPTH; i++) begin
      add_row(OP_RD, i * 4, 32'h0);
    end
    // above the top word with bits 1:0 set and aliasing word 1
    add_row(OP_WR, DEPTH * 4 + 4 + 3, lcg_next());
    add_row(OP_RD, 4, 32'h0);
    add_row(OP_RD, 0, 32'h0);
    add_row(OP_RUN, 0, lcg_next());
    add_row(OP_WR, 8, lcg_next());
    add_row(OP_WR, (DEPTH - 1) * 4 + 1, lcg_next());
    add_row(OP_RD, 8, 32'h0);
    add_row(OP_RUN, 0, lcg_next());
    add_row(OP_RD, (DEPTH - 1) * 4, 32'h0);

    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("rvalid_o", rvalid_o, 32'h0);
    check_value("epu_finish_o", epu_finish_o, 32'h0);
    check_value("result_o", result_o, 32'h0);

    foreach (rows[i]) begin
      case (rows[i].op)
        OP_WR:   host_write(rows[i].addr, rows[i].data);
        OP_RD:   host_read(rows[i].addr, rows[i].exp_val);
        default: run_engine(rows[i].data, rows[i].exp_val);
      endcase
    end

    @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

// File: src.f
hdl/conv_acc_pkg.sv
hdl/param_sram.sv
hdl/param_wrapper.sv
hdl/conv_dot_engine.sv
hdl/conv_param_top.sv
tests/tb_conv_param.sv
